// ==== project.f ====
hw/rvPkg.sv
hw/alu.sv
hw/regFile.sv
hw/immGen.sv
hw/loadStoreUnit.sv
hw/pcUnit.sv
hw/controller.sv
hw/rvCore.sv
sim/rvCoreTb.sv

// ==== sim/rvCoreTb.sv ====
`timescale 1ns/10ps

module rvCoreTb;

    logic        clk;
    logic        rstN;
    logic [31:0] imemData;
    logic [31:0] dmemRData;
    logic [31:0] imemAddr;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWData;
    logic [3:0]  dmemByteEn;
    logic        dmemWe;

    logic [31:0] imem [256];
    logic [31:0] dmem [64];

    // Expected stores in program order
    string       expName [64];
    logic [31:0] expAddr [64];
    logic [3:0]  expBe [64];
    logic [31:0] expData [64];

    int          progLen;
    int          numExp;
    int          matched;
    int          cycles;
    int          timeoutLimit;
    logic [31:0] slot;    // Next free result word
    integer      seed;
    logic [31:0] regA;    // x1
    logic [31:0] regB;    // x2
    logic [31:0] pattern; // x9 after LUI and ADDI

    rvCore UUT (
        .clk(clk), .rstN(rstN), .imemData(imemData), .dmemRData(dmemRData),
        .imemAddr(imemAddr), .dmemAddr(dmemAddr), .dmemWData(dmemWData),
        .dmemByteEn(dmemByteEn), .dmemWe(dmemWe)
    );

    always #2 clk = ~clk;

    assign imemData  = imem[imemAddr[9:2]];
    assign dmemRData = dmem[dmemAddr[7:2]];

    always @(posedge clk) begin
        if (dmemWe) begin
            for (int b = 0; b < 4; b++) begin
                if (dmemByteEn[b]) begin
                    dmem[dmemAddr[7:2]][8*b +: 8] <= dmemWData[8*b +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rvPkg::opOp, 2'b11};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input rvPkg::opcodeT op);
        return {imm, rs1, f3, rd, op, 2'b11};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], rvPkg::opStore, 2'b11}; // Base x0
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvPkg::opBranch, 2'b11};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rvPkg::opJal, 2'b11};
    endfunction

    // RV32I branch conditions
    function automatic bit branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] byteMask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            failRun($sformatf("Error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic putWord(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic addExpected(input string name, input logic [31:0] addr,
                               input logic [3:0] be, input logic [31:0] data);
        expName[numExp] = name;
        expAddr[numExp] = addr;
        expBe[numExp]   = be;
        expData[numExp] = data;
        numExp++;
    endtask

    task automatic storeAndExpect(input string name, input logic [4:0] rs,
                                  input logic [31:0] value);
        putWord(sType(slot[11:0], rs, 3'b010)); // SW rs, slot(x0)
        addExpected(name, slot, 4'hF, value);
        slot += 4;
    endtask

    task automatic regOpTest(input string name, input logic [6:0] f7, input logic [2:0] f3,
                             input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [31:0] value);
        putWord(rType(f7, rs2, rs1, f3, 5'd4));
        storeAndExpect(name, 5'd4, value);
    endtask

    task automatic immOpTest(input string name, input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [11:0] imm, input logic [31:0] value);
        putWord(iType(imm, rs1, f3, 5'd5, rvPkg::opOpImm));
        storeAndExpect(name, 5'd5, value);
    endtask

    task automatic loadTest(input string name, input logic [2:0] f3, input logic [11:0] addr,
                            input logic [31:0] value);
        putWord(iType(addr, 5'd0, f3, 5'd8, rvPkg::opLoad));
        storeAndExpect(name, 5'd8, value);
    endtask

    // Wrong path stores the x7 marker into the same slot
    task automatic branchTest(input string name, input logic [2:0] f3, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic [31:0] a, input logic [31:0] b);
        putWord(bType(13'd8, rs2, rs1, f3));
        if (branchTaken(f3, a, b)) begin
            putWord(sType(slot[11:0], 5'd7, 3'b010)); // Skipped when taken
        end
        storeAndExpect(name, 5'd6, 32'h5A5);
    endtask

    task automatic buildProgram();
        int jalAt;
        int jalrAt;
        putWord(iType(12'd100, 5'd0, 3'b000, 5'd1, rvPkg::opOpImm)); // Word 0 is no store
        putWord(iType(12'hFF9, 5'd0, 3'b000, 5'd2, rvPkg::opOpImm)); // x2 = -7
        putWord(iType(12'd3, 5'd0, 3'b000, 5'd3, rvPkg::opOpImm));
        putWord(iType(12'h5A5, 5'd0, 3'b000, 5'd6, rvPkg::opOpImm)); // Good-path marker
        putWord(iType(12'h3BA, 5'd0, 3'b000, 5'd7, rvPkg::opOpImm)); // Wrong-path marker

        regOpTest("ADD",  7'h00, 3'b000, 5'd1, 5'd2, regA + regB);
        regOpTest("SUB",  7'h20, 3'b000, 5'd1, 5'd2, regA - regB);
        regOpTest("AND",  7'h00, 3'b111, 5'd1, 5'd2, regA & regB);
        regOpTest("OR",   7'h00, 3'b110, 5'd1, 5'd2, regA | regB);
        regOpTest("XOR",  7'h00, 3'b100, 5'd1, 5'd2, regA ^ regB);
        regOpTest("SLL",  7'h00, 3'b001, 5'd1, 5'd3, regA << 3);
        regOpTest("SRL",  7'h00, 3'b101, 5'd2, 5'd3, regB >> 3);
        regOpTest("SRA",  7'h20, 3'b101, 5'd2, 5'd3, $unsigned($signed(regB) >>> 3));
        regOpTest("SLT",  7'h00, 3'b010, 5'd2, 5'd1, {31'd0, $signed(regB) < $signed(regA)});
        regOpTest("SLTU", 7'h00, 3'b011, 5'd2, 5'd1, {31'd0, regB < regA});

        immOpTest("ADDI",  3'b000, 5'd1, 12'hED4, regA - 32'd300);
        immOpTest("XORI",  3'b100, 5'd2, 12'h0F0, regB ^ 32'h0F0);
        immOpTest("ANDI",  3'b111, 5'd2, 12'h7F0, regB & 32'h7F0);
        immOpTest("SLLI",  3'b001, 5'd1, 12'h004, regA << 4);
        immOpTest("SRAI",  3'b101, 5'd2, 12'h402, $unsigned($signed(regB) >>> 2));
        immOpTest("SLTIU", 3'b011, 5'd1, 12'hFFF, {31'd0, regA < 32'hFFFFFFFF});

        putWord({20'h89ABD, 5'd9, rvPkg::opLui, 2'b11});
        storeAndExpect("LUI", 5'd9, 32'h89ABD000);
        putWord(iType(12'hDEF, 5'd9, 3'b000, 5'd9, rvPkg::opOpImm));
        storeAndExpect("LUI then ADDI", 5'd9, pattern);
        putWord({20'h00012, 5'd5, rvPkg::opAuipc, 2'b11});
        storeAndExpect("AUIPC", 5'd5, 32'((progLen - 1) * 4) + 32'h12000);

        loadTest("LW",  3'b010, 12'd0,  dmem[0]);
        loadTest("LB",  3'b000, 12'd1,  {{24{dmem[0][15]}}, dmem[0][15:8]});
        loadTest("LBU", 3'b100, 12'd7,  {24'd0, dmem[1][31:24]});
        loadTest("LH",  3'b001, 12'd10, {{16{dmem[2][31]}}, dmem[2][31:16]});
        loadTest("LHU", 3'b101, 12'd12, {16'd0, dmem[3][15:0]});

        for (int k = 0; k < 4; k++) begin
            putWord(sType(slot[11:0] + k, 5'd9, 3'b000));
            addExpected($sformatf("SB lane %0d", k), slot + k, 4'b0001 << k,
                        {24'd0, pattern[7:0]} << (8 * k));
        end
        slot += 4;
        for (int h = 0; h < 2; h++) begin
            putWord(sType(slot[11:0] + 2 * h, 5'd9, 3'b001));
            addExpected($sformatf("SH lane %0d", h), slot + 2 * h, 4'b0011 << (2 * h),
                        {16'd0, pattern[15:0]} << (16 * h));
        end
        slot += 4;

        branchTest("BEQ taken",      3'b000, 5'd1, 5'd1, regA, regA);
        branchTest("BEQ not taken",  3'b000, 5'd1, 5'd2, regA, regB);
        branchTest("BNE taken",      3'b001, 5'd1, 5'd2, regA, regB);
        branchTest("BNE not taken",  3'b001, 5'd1, 5'd1, regA, regA);
        branchTest("BLT taken",      3'b100, 5'd2, 5'd1, regB, regA);
        branchTest("BLT not taken",  3'b100, 5'd1, 5'd2, regA, regB);
        branchTest("BGE taken",      3'b101, 5'd1, 5'd2, regA, regB);
        branchTest("BGE not taken",  3'b101, 5'd2, 5'd1, regB, regA);
        branchTest("BLTU taken",     3'b110, 5'd1, 5'd2, regA, regB);
        branchTest("BLTU not taken", 3'b110, 5'd2, 5'd1, regB, regA);
        branchTest("BGEU taken",     3'b111, 5'd2, 5'd1, regB, regA);
        branchTest("BGEU not taken", 3'b111, 5'd1, 5'd2, regA, regB);

        jalAt = progLen * 4;
        putWord(jType(21'd12, 5'd10));
        putWord(sType(slot[11:0], 5'd7, 3'b010)); // Only reached if the jump fails
        putWord(sType(slot[11:0], 5'd7, 3'b010));
        storeAndExpect("JAL link at target", 5'd10, jalAt + 4);

        jalrAt = progLen * 4 + 4;
        putWord(iType(12'(jalrAt + 10), 5'd0, 3'b000, 5'd11, rvPkg::opOpImm));
        putWord(iType(12'd3, 5'd11, 3'b000, 5'd12, rvPkg::opJalr)); // Odd sum, bit 0 dropped
        putWord(sType(slot[11:0], 5'd7, 3'b010));
        putWord(sType(slot[11:0], 5'd7, 3'b010));
        storeAndExpect("JALR link at target", 5'd12, jalrAt + 4);
        putWord(jType(21'd0, 5'd0)); // Park here
    endtask

    initial begin
        clk      = 1'b0;
        rstN     = 1'b0;
        progLen  = 0;
        numExp   = 0;
        matched  = 0;
        cycles   = 0;
        slot     = 32'h10; // Words 0 to 3 stay as load sources
        seed     = 32'hf480;
        regA     = 32'd100;
        regB     = 32'hFFFFFFF9;
        pattern  = 32'h89ABD000 + {{20{1'b1}}, 12'hDEF};
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $random(seed);
        end
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h00000013; // NOP
        end
        buildProgram();
        timeoutLimit = progLen * 4 + 20;

        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (dmemWe !== 1'b0) begin
                failRun("A store was issued while reset was held");
            end
        end
        @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("First fetch after reset", 32'h0, imemAddr);

        while (matched < numExp) begin
            if (cycles >= timeoutLimit) begin
                failRun($sformatf("Timeout after %0d cycles, store %s never appeared",
                                  cycles, expName[matched]));
            end
            // Catches a JALR target that kept bit 0
            checkValue("Fetch address alignment", 32'h0, {30'd0, imemAddr[1:0]});
            if (dmemWe) begin
                checkValue($sformatf("%s address", expName[matched]), expAddr[matched],
                           dmemAddr);
                checkValue($sformatf("%s byteEn", expName[matched]), {28'd0, expBe[matched]},
                           {28'd0, dmemByteEn});
                checkValue($sformatf("%s data", expName[matched]),
                           expData[matched] & byteMask(expBe[matched]),
                           dmemWData & byteMask(expBe[matched]));
                matched++;
            end
            cycles++;
            @(negedge clk);
        end

        // Core should now sit in its final loop
        repeat (8) begin
            if (dmemWe) begin
                failRun($sformatf("Unexpected store to address %h after the last expected one",
                                  dmemAddr));
            end
            @(negedge clk);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== hw/rvCore.sv ====
`timescale 1ns/10ps

module rvCore (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [31:0]            imemData,
    input  logic [rvPkg::xlen-1:0] dmemRData,
    output logic [rvPkg::xlen-1:0] imemAddr,
    output logic [rvPkg::xlen-1:0] dmemAddr,
    output logic [rvPkg::xlen-1:0] dmemWData,
    output logic [3:0]             dmemByteEn,
    output logic                   dmemWe
);

    rvPkg::aluOpT           aluCtrl;
    rvPkg::accSizeT         loadSel;
    rvPkg::accSizeT         maskSel;
    rvPkg::wbSelT           regDataSel;
    logic                   aluImm;
    logic                   aluToPc;
    logic                   branch;
    logic                   memToReg;
    logic                   memWr;
    logic                   regWr;
    logic                   regWrGated;
    logic                   rs2ShiftSel;
    logic                   uext;
    logic                   aluZero;
    logic [rvPkg::xlen-1:0] pc;
    logic [rvPkg::xlen-1:0] imm;
    logic [rvPkg::xlen-1:0] rs1Data;
    logic [rvPkg::xlen-1:0] rs2Data;
    logic [rvPkg::xlen-1:0] aluB;
    logic [rvPkg::xlen-1:0] aluResult;
    logic [rvPkg::xlen-1:0] loadData;
    logic [rvPkg::xlen-1:0] wbData;
    logic [rvPkg::regAddrW-1:0] rs1Addr;
    logic [rvPkg::regAddrW-1:0] rs2Addr;
    logic [rvPkg::regAddrW-1:0] rdAddr;

    assign rs1Addr = imemData[19:15];
    assign rs2Addr = imemData[24:20];
    assign rdAddr  = imemData[11:7];

    controller uCtrl (
        .instruction(imemData), .aluZero(aluZero), .aluCtrl(aluCtrl), .aluImm(aluImm),
        .aluToPc(aluToPc), .branch(branch), .loadSel(loadSel), .maskSel(maskSel),
        .memToReg(memToReg), .memWr(memWr), .regDataSel(regDataSel), .regWr(regWr),
        .rs2ShiftSel(rs2ShiftSel), .uext(uext)
    );

    immGen uImm (.instruction(imemData), .imm(imm));

    assign regWrGated = regWr & rstN; // No writeback while held in reset

    regFile uRegs (
        .clk(clk), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rdAddr(rdAddr),
        .wrEn(regWrGated), .wrData(wbData), .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    assign aluB = aluImm ? imm : rs2Data;

    alu uAlu (.op(aluCtrl), .a(rs1Data), .b(aluB), .result(aluResult), .zero(aluZero));

    loadStoreUnit uLsu (
        .addrLow(aluResult[1:0]), .storeData(rs2Data), .maskSel(maskSel), .loadSel(loadSel),
        .rs2ShiftSel(rs2ShiftSel), .uext(uext), .memWr(memWr), .memRData(dmemRData),
        .byteEn(dmemByteEn), .wData(dmemWData), .loadData(loadData)
    );

    pcUnit uPc (
        .clk(clk), .rstN(rstN), .branch(branch), .aluToPc(aluToPc), .imm(imm),
        .aluResult(aluResult), .pc(pc)
    );

    always_comb begin
        case (regDataSel)
            rvPkg::wbLui:   wbData = imm;
            rvPkg::wbAuipc: wbData = pc + imm;
            rvPkg::wbLink:  wbData = pc + 32'd4; // Return address
            default:        wbData = memToReg ? loadData : aluResult;
        endcase
    end

    assign imemAddr = pc;
    assign dmemAddr = aluResult;
    assign dmemWe   = memWr;

endmodule

// ==== hw/controller.sv ====
`timescale 1ns/10ps

module controller (
    input  logic [31:0]    instruction,
    input  logic           aluZero,
    output rvPkg::aluOpT   aluCtrl,
    output logic           aluImm,
    output logic           aluToPc,
    output logic           branch,
    output rvPkg::accSizeT loadSel,
    output rvPkg::accSizeT maskSel,
    output logic           memToReg,
    output logic           memWr,
    output rvPkg::wbSelT   regDataSel,
    output logic           regWr,
    output logic           rs2ShiftSel,
    output logic           uext
);

    logic [2:0]    funct3;
    logic [6:0]    funct7;
    rvPkg::opcodeT opcode;

    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign opcode = rvPkg::opcodeT'(instruction[6:2]); // Low two bits always 11

    always_comb begin
        // Defaults describe a no-op
        aluCtrl     = rvPkg::aluAdd;
        aluImm      = 1'b0;
        aluToPc     = 1'b0;
        branch      = 1'b0;
        loadSel     = rvPkg::accSizeT'(funct3[1:0]);
        maskSel     = rvPkg::accSizeT'(funct3[1:0]);
        memToReg    = 1'b0;
        memWr       = 1'b0;
        regDataSel  = rvPkg::wbAlu;
        regWr       = 1'b0;
        rs2ShiftSel = funct3[0]; // Halfword lane replication for SH
        uext        = funct3[2]; // LBU and LHU

        case (opcode)
            rvPkg::opOp: begin
                regWr = 1'b1;
                case (funct3)
                    3'b000:  aluCtrl = funct7[5] ? rvPkg::aluSub : rvPkg::aluAdd;
                    3'b001:  aluCtrl = rvPkg::aluSll;
                    3'b010:  aluCtrl = rvPkg::aluSlt;
                    3'b011:  aluCtrl = rvPkg::aluSltu;
                    3'b100:  aluCtrl = rvPkg::aluXor;
                    3'b101:  aluCtrl = funct7[5] ? rvPkg::aluSra : rvPkg::aluSrl;
                    3'b110:  aluCtrl = rvPkg::aluOr;
                    default: aluCtrl = rvPkg::aluAnd;
                endcase
            end

            rvPkg::opOpImm: begin
                aluImm = 1'b1;
                regWr  = 1'b1;
                case (funct3)
                    3'b001:  aluCtrl = rvPkg::aluSll;
                    3'b010:  aluCtrl = rvPkg::aluSlt;
                    3'b011:  aluCtrl = rvPkg::aluSltu;
                    3'b100:  aluCtrl = rvPkg::aluXor;
                    3'b101:  aluCtrl = funct7[5] ? rvPkg::aluSra : rvPkg::aluSrl;
                    3'b110:  aluCtrl = rvPkg::aluOr;
                    3'b111:  aluCtrl = rvPkg::aluAnd;
                    default: aluCtrl = rvPkg::aluAdd; // ADDI
                endcase
            end

            rvPkg::opLoad: begin
                aluImm   = 1'b1; // Address is rs1 + imm
                memToReg = 1'b1;
                regWr    = 1'b1;
            end

            rvPkg::opStore: begin
                aluImm = 1'b1;
                memWr  = 1'b1;
            end

            rvPkg::opBranch: begin
                // Compare in the ALU, then test the zero flag
                case (funct3)
                    3'b000: begin // BEQ
                        aluCtrl = rvPkg::aluSub;
                        branch  = aluZero;
                    end
                    3'b001: begin // BNE
                        aluCtrl = rvPkg::aluSub;
                        branch  = ~aluZero;
                    end
                    3'b100: begin // BLT
                        aluCtrl = rvPkg::aluSlt;
                        branch  = ~aluZero;
                    end
                    3'b101: begin // BGE
                        aluCtrl = rvPkg::aluSlt;
                        branch  = aluZero;
                    end
                    3'b110: begin // BLTU
                        aluCtrl = rvPkg::aluSltu;
                        branch  = ~aluZero;
                    end
                    3'b111: begin // BGEU
                        aluCtrl = rvPkg::aluSltu;
                        branch  = aluZero;
                    end
                    default: branch = 1'b0;
                endcase
            end

            rvPkg::opJalr: begin
                aluImm     = 1'b1;
                aluToPc    = 1'b1; // Target from rs1 + imm
                branch     = 1'b1;
                regDataSel = rvPkg::wbLink;
                regWr      = 1'b1;
            end

            rvPkg::opJal: begin
                branch     = 1'b1;
                regDataSel = rvPkg::wbLink;
                regWr      = 1'b1;
            end

            rvPkg::opLui: begin
                regDataSel = rvPkg::wbLui;
                regWr      = 1'b1;
            end

            rvPkg::opAuipc: begin
                regDataSel = rvPkg::wbAuipc;
                regWr      = 1'b1;
            end

            rvPkg::opMiscMem: regWr = 1'b0; // FENCE is a no-op here
            rvPkg::opSystem:  regWr = 1'b0; // No traps or CSRs

            default: regWr = 1'b0;
        endcase
    end

endmodule

// ==== hw/pcUnit.sv ====
`timescale 1ns/10ps

module pcUnit (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   branch,
    input  logic                   aluToPc,
    input  logic [rvPkg::xlen-1:0] imm,
    input  logic [rvPkg::xlen-1:0] aluResult,
    output logic [rvPkg::xlen-1:0] pc
);

    logic [rvPkg::xlen-1:0] nextPc;

    always_comb begin
        if (branch && aluToPc) begin
            nextPc = {aluResult[rvPkg::xlen-1:1], 1'b0}; // JALR clears bit 0
        end else if (branch) begin
            nextPc = pc + imm; // Taken branch or JAL
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// ==== hw/loadStoreUnit.sv ====
`timescale 1ns/10ps

module loadStoreUnit (
    input  logic [1:0]             addrLow,
    input  logic [rvPkg::xlen-1:0] storeData,
    input  rvPkg::accSizeT         maskSel,
    input  rvPkg::accSizeT         loadSel,
    input  logic                   rs2ShiftSel,
    input  logic                   uext,
    input  logic                   memWr,
    input  logic [rvPkg::xlen-1:0] memRData,
    output logic [3:0]             byteEn,
    output logic [rvPkg::xlen-1:0] wData,
    output logic [rvPkg::xlen-1:0] loadData
);

    logic [4:0]             shiftAmt;
    logic [rvPkg::xlen-1:0] shifted;
    logic [3:0]             laneMask;

    // Store path, data copied to every lane so memory picks by byteEn
    always_comb begin
        if (maskSel == rvPkg::sizeWord) begin
            wData = storeData;
        end else if (rs2ShiftSel) begin
            wData = {2{storeData[15:0]}}; // SH
        end else begin
            wData = {4{storeData[7:0]}}; // SB
        end
    end

    always_comb begin
        case (maskSel)
            rvPkg::sizeByte: laneMask = 4'b0001 << addrLow;
            rvPkg::sizeHalf: laneMask = addrLow[1] ? 4'b1100 : 4'b0011;
            default:         laneMask = 4'b1111;
        endcase
    end

    assign byteEn = memWr ? laneMask : 4'b0000;

    // Load path, addressed lane moved to bit 0
    assign shiftAmt = {addrLow, 3'b000};
    assign shifted  = memRData >> shiftAmt;

    always_comb begin
        case (loadSel)
            rvPkg::sizeByte: begin
                loadData = {{24{~uext & shifted[7]}}, shifted[7:0]};
            end
            rvPkg::sizeHalf: begin
                loadData = {{16{~uext & shifted[15]}}, shifted[15:0]};
            end
            default: loadData = memRData; // LW
        endcase
    end

endmodule

// ==== hw/immGen.sv ====
`timescale 1ns/10ps

module immGen (
    input  logic [31:0]            instruction,
    output logic [rvPkg::xlen-1:0] imm
);

    rvPkg::opcodeT opcode;
    logic          sign;

    assign opcode = rvPkg::opcodeT'(instruction[6:2]);
    assign sign   = instruction[31];

    always_comb begin
        case (opcode)
            rvPkg::opStore: begin // S-type
                imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            end
            rvPkg::opBranch: begin // B-type, bit 0 always zero
                imm = {{19{sign}}, sign, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            end
            rvPkg::opLui,
            rvPkg::opAuipc: begin // U-type
                imm = {instruction[31:12], 12'b0};
            end
            rvPkg::opJal: begin // J-type
                imm = {{11{sign}}, sign, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            end
            default: begin
                // I-type covers loads, OP-IMM and JALR
                imm = {{20{sign}}, instruction[31:20]};
            end
        endcase
    end

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/10ps

module regFile (
    input  logic                       clk,
    input  logic [rvPkg::regAddrW-1:0] rs1Addr,
    input  logic [rvPkg::regAddrW-1:0] rs2Addr,
    input  logic [rvPkg::regAddrW-1:0] rdAddr,
    input  logic                       wrEn,
    input  logic [rvPkg::xlen-1:0]     wrData,
    output logic [rvPkg::xlen-1:0]     rs1Data,
    output logic [rvPkg::xlen-1:0]     rs2Data
);

    localparam int numRegs = 2 ** rvPkg::regAddrW;

    // x0 has no storage
    logic [rvPkg::xlen-1:0] regs [numRegs-1:1];

    always_ff @(posedge clk) begin
        if (wrEn && (rdAddr != '0)) begin
            regs[rdAddr] <= wrData;
        end
    end

    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  rvPkg::aluOpT           op,
    input  logic [rvPkg::xlen-1:0] a,
    input  logic [rvPkg::xlen-1:0] b,
    output logic [rvPkg::xlen-1:0] result,
    output logic                   zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0]; // RV32I shifts use five bits

    always_comb begin
        case (op)
            rvPkg::aluAdd:  result = a + b;
            rvPkg::aluSub:  result = a - b;
            rvPkg::aluAnd:  result = a & b;
            rvPkg::aluOr:   result = a | b;
            rvPkg::aluXor:  result = a ^ b;
            rvPkg::aluSll:  result = a << shamt;
            rvPkg::aluSrl:  result = a >> shamt;
            rvPkg::aluSra:  result = $signed(a) >>> shamt;
            rvPkg::aluSlt: begin
                result    = '0;
                result[0] = $signed(a) < $signed(b);
            end
            rvPkg::aluSltu: begin
                result    = '0;
                result[0] = a < b;
            end
            default: result = '0;
        endcase
    end

    // Branch decisions in the controller rely on this
    assign zero = (result == '0);

endmodule

// ==== hw/rvPkg.sv ====
package rvPkg;

    localparam int xlen     = 32; // Data and address width
    localparam int regAddrW = 5;  // Register index width

    // Opcode bits 6 to 2; bits 1 and 0 are always 11 for RV32I
    typedef enum logic [4:0] {
        opLoad    = 5'b00000,
        opMiscMem = 5'b00011, // FENCE
        opOpImm   = 5'b00100,
        opAuipc   = 5'b00101,
        opStore   = 5'b01000,
        opOp      = 5'b01100,
        opLui     = 5'b01101,
        opBranch  = 5'b11000,
        opJalr    = 5'b11001,
        opJal     = 5'b11011,
        opSystem  = 5'b11100  // ECALL, EBREAK, Zicsr
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSub  = 4'b0001,
        aluAnd  = 4'b0010,
        aluOr   = 4'b0011,
        aluXor  = 4'b0100,
        aluSll  = 4'b0101,
        aluSrl  = 4'b0110,
        aluSra  = 4'b0111,
        aluSlt  = 4'b1000,
        aluSltu = 4'b1001
    } aluOpT;

    // Register writeback source
    typedef enum logic [1:0] {
        wbAlu   = 2'b00, // ALU result or load data
        wbAuipc = 2'b01, // pc + imm
        wbLui   = 2'b10, // Immediate
        wbLink  = 2'b11  // pc + 4
    } wbSelT;

    // Matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        sizeByte = 2'b00,
        sizeHalf = 2'b01,
        sizeWord = 2'b10
    } accSizeT;

endpackage
